/* hw/fc_io_pkg.sv */
// ==============================
// Flight-controller IO shared definitions
// Bus widths, address map, register offsets and structs
// ==============================
package fc_io_pkg;

    // Bus and peripheral sizes
    localparam int WB_ADDR_W = 32;
    localparam int WB_DATA_W = 32;
    localparam int N_MOTORS  = 4;
    localparam int N_LEDS    = 5;

    typedef logic [WB_ADDR_W-1:0] wb_addr_t;
    typedef logic [WB_DATA_W-1:0] wb_data_t;
    typedef logic [N_MOTORS-1:0]  motor_vec_t;

    // ==============================
    // Address map, 256-byte windows
    // ==============================
    localparam wb_addr_t WIN_LED   = 32'h0000_0000;
    localparam wb_addr_t WIN_DSHOT = 32'h0000_0300;
    localparam wb_addr_t WIN_MODE  = 32'h0000_0400;
    // Upper bits above the window offset
    localparam wb_addr_t WIN_MASK  = 32'hFFFF_FF00;

    // Register offsets inside a window
    // Motor n throttle lives at DSHOT_THR_OFS + 4*n
    localparam logic [7:0] DSHOT_THR_OFS    = 8'h00;
    localparam logic [7:0] DSHOT_STATUS_OFS = 8'h10;
    localparam logic [7:0] MODE_OFS         = 8'h00;

    // Wishbone classic request, master to slave
    typedef struct packed {
        wb_addr_t   adr;
        wb_data_t   dat;
        logic       we;
        logic [3:0] sel;
        logic       stb;
        logic       cyc;
    } wb_req_t;

    // Wishbone response, slave to master
    typedef struct packed {
        wb_data_t dat;
        logic     ack;
        logic     err;
    } wb_rsp_t;

    // DSHOT frame, sent MSB first
    localparam int DSHOT_FRAME_BITS = 16;
    typedef struct packed {
        logic [10:0] throttle;
        logic        telem;
        logic [3:0]  crc;
    } dshot_frame_t;

endpackage

/* hw/dshot_tx.sv */
// ==============================
// DSHOT frame serializer for one motor line
// ==============================
`timescale 1ns/1ps

module dshot_tx #(
    parameter int BIT_CYCLES = 120
) (
    input  logic                    i_sys_clk,
    input  logic                    sys_rst,
    input  logic                    i_start_i,
    input  fc_io_pkg::dshot_frame_t i_frame_i,
    output logic                    o_line_o,
    output logic                    o_busy_o
);
    import fc_io_pkg::*;

    localparam int CNT_W = $clog2(BIT_CYCLES);
    localparam int BIT_W = $clog2(DSHOT_FRAME_BITS);

    // High-time thresholds, rounded down
    localparam logic [CNT_W-1:0] LAST_CYC = CNT_W'(BIT_CYCLES - 1);
    localparam logic [CNT_W-1:0] HI_ONE   = CNT_W'((BIT_CYCLES * 3) / 4);
    localparam logic [CNT_W-1:0] HI_ZERO  = CNT_W'((BIT_CYCLES * 3) / 8);
    localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(DSHOT_FRAME_BITS - 1);

    logic [DSHOT_FRAME_BITS-1:0] shift_q;
    logic [BIT_W-1:0]            bit_cnt;
    logic [CNT_W-1:0]            cyc_cnt;
    logic [CNT_W-1:0]            cyc_nxt;
    logic [CNT_W-1:0]            hi_cycles;
    logic                        busy_q;
    logic                        line_q;

    assign cyc_nxt   = cyc_cnt + 1'b1;
    // Current bit is always the shift register MSB
    assign hi_cycles = shift_q[DSHOT_FRAME_BITS-1] ? HI_ONE : HI_ZERO;

    always_ff @(posedge i_sys_clk) begin
        if (sys_rst) begin
            busy_q  <= 1'b0;
            line_q  <= 1'b0;
            bit_cnt <= '0;
            cyc_cnt <= '0;
        end else if (!busy_q) begin
            if (i_start_i) begin
                // Every bit opens with a high phase
                busy_q  <= 1'b1;
                line_q  <= 1'b1;
                bit_cnt <= '0;
                cyc_cnt <= '0;
            end
        end else if (cyc_cnt == LAST_CYC) begin
            cyc_cnt <= '0;
            if (bit_cnt == LAST_BIT) begin
                // Frame done, line back to idle
                busy_q <= 1'b0;
                line_q <= 1'b0;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
                line_q  <= 1'b1;
            end
        end else begin
            cyc_cnt <= cyc_nxt;
            line_q  <= cyc_nxt < hi_cycles;
        end
    end

    // Shift data, loaded on start and advanced per bit
    always_ff @(posedge i_sys_clk) begin
        if (!busy_q && i_start_i) begin
            shift_q <= i_frame_i;
        end else if (busy_q && cyc_cnt == LAST_CYC) begin
            shift_q <= shift_q << 1;
        end
    end

    assign o_line_o = line_q;
    assign o_busy_o = busy_q;

    // Idle serializer keeps the line low
    a_idle_low: assert property (@(posedge i_sys_clk) disable iff (sys_rst)
        !o_busy_o |-> !o_line_o);

endmodule

/* hw/wb_addr_decoder.sv */
// ==============================
// Wishbone address decoder
// Routes a request by window, errors on unmapped addresses
// ==============================
`timescale 1ns/1ps

module wb_addr_decoder (
    input  logic               i_sys_clk,
    input  logic               sys_rst,
    input  fc_io_pkg::wb_req_t i_req_i,
    input  fc_io_pkg::wb_rsp_t i_led_rsp_i,
    input  fc_io_pkg::wb_rsp_t i_dshot_rsp_i,
    input  fc_io_pkg::wb_rsp_t i_mode_rsp_i,
    output fc_io_pkg::wb_rsp_t o_rsp_o,
    output fc_io_pkg::wb_req_t o_led_req_o,
    output fc_io_pkg::wb_req_t o_dshot_req_o,
    output fc_io_pkg::wb_req_t o_mode_req_o
);
    import fc_io_pkg::*;

    logic hit_led;
    logic hit_dshot;
    logic hit_mode;
    logic req_act;
    logic err_q;

    // Window match on the upper address bits
    assign hit_led   = (i_req_i.adr & WIN_MASK) == WIN_LED;
    assign hit_dshot = (i_req_i.adr & WIN_MASK) == WIN_DSHOT;
    assign hit_mode  = (i_req_i.adr & WIN_MASK) == WIN_MODE;
    assign req_act   = i_req_i.cyc & i_req_i.stb;

    // Fan out the request, strobe only to the matching slave
    always_comb begin
        o_led_req_o       = i_req_i;
        o_led_req_o.stb   = i_req_i.stb & hit_led;
        o_led_req_o.cyc   = i_req_i.cyc & hit_led;
        o_dshot_req_o     = i_req_i;
        o_dshot_req_o.stb = i_req_i.stb & hit_dshot;
        o_dshot_req_o.cyc = i_req_i.cyc & hit_dshot;
        o_mode_req_o      = i_req_i;
        o_mode_req_o.stb  = i_req_i.stb & hit_mode;
        o_mode_req_o.cyc  = i_req_i.cyc & hit_mode;
    end

    // Unmapped access gets a one-cycle err, like a slave ack
    always_ff @(posedge i_sys_clk) begin
        if (sys_rst) begin
            err_q <= 1'b0;
        end else begin
            err_q <= req_act & ~(hit_led | hit_dshot | hit_mode) & ~err_q;
        end
    end

    // Response back from whichever window holds the address
    always_comb begin
        if (hit_led) begin
            o_rsp_o = i_led_rsp_i;
        end else if (hit_dshot) begin
            o_rsp_o = i_dshot_rsp_i;
        end else if (hit_mode) begin
            o_rsp_o = i_mode_rsp_i;
        end else begin
            o_rsp_o     = '0;
            o_rsp_o.err = err_q;
        end
    end

    // Windows never overlap, so at most one slave sees a strobe
    a_one_slave: assert property (@(posedge i_sys_clk) disable iff (sys_rst)
        $onehot0({o_led_req_o.stb, o_dshot_req_o.stb, o_mode_req_o.stb}));

endmodule

/* hw/wb_led_ctrl.sv */
// ==============================
// LED output register with readback
// ==============================
`timescale 1ns/1ps

module wb_led_ctrl #(
    parameter bit LED_ACTIVE_LOW = 1'b1
) (
    input  logic                         i_sys_clk,
    input  logic                         sys_rst,
    input  fc_io_pkg::wb_req_t           i_req_i,
    output fc_io_pkg::wb_rsp_t           o_rsp_o,
    output logic [fc_io_pkg::N_LEDS-1:0] o_led_o
);
    import fc_io_pkg::*;

    logic [N_LEDS-1:0] led_q;
    logic              ack_q;
    logic              access;

    // New access only while no ack is outstanding
    assign access = i_req_i.cyc & i_req_i.stb & ~ack_q;

    always_ff @(posedge i_sys_clk) begin
        if (sys_rst) begin
            led_q <= '0;
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
            // Low byte lane carries the LED bits
            if (access && i_req_i.we && i_req_i.sel[0]) begin
                led_q <= i_req_i.dat[N_LEDS-1:0];
            end
        end
    end

    assign o_rsp_o.dat = wb_data_t'(led_q);
    assign o_rsp_o.ack = ack_q;
    assign o_rsp_o.err = 1'b0;

    // Board LEDs sink current, so a set bit pulls the pin low
    assign o_led_o = LED_ACTIVE_LOW ? ~led_q : led_q;

endmodule

/* hw/wb_dshot_ctrl.sv */
// ==============================
// DSHOT register block
// Builds frames with checksum and starts one serializer per motor
// ==============================
`timescale 1ns/1ps

module wb_dshot_ctrl #(
    parameter int DSHOT_BIT_CYCLES = 120
) (
    input  logic                  i_sys_clk,
    input  logic                  sys_rst,
    input  fc_io_pkg::wb_req_t    i_req_i,
    output fc_io_pkg::wb_rsp_t    o_rsp_o,
    output fc_io_pkg::motor_vec_t o_dshot_o
);
    import fc_io_pkg::*;

    localparam int MOT_W = $clog2(N_MOTORS);

    logic         ack_q;
    logic         access;
    logic [7:0]   ofs;
    logic [7:0]   thr_ofs;
    logic         thr_hit;
    logic [MOT_W-1:0] mot_idx;
    logic [11:0]  cmd;
    dshot_frame_t new_frame;
    dshot_frame_t frame_q [N_MOTORS];
    motor_vec_t   start_q;
    motor_vec_t   busy;

    assign access  = i_req_i.cyc & i_req_i.stb & ~ack_q;
    assign ofs     = i_req_i.adr[7:0];
    // Throttle registers sit on word steps from DSHOT_THR_OFS
    assign thr_ofs = ofs - DSHOT_THR_OFS;
    assign thr_hit = (thr_ofs < 8'(4 * N_MOTORS)) && (thr_ofs[1:0] == 2'b00);
    assign mot_idx = thr_ofs[MOT_W+1:2];

    // Throttle and telemetry request form the 12-bit command
    assign cmd                = {i_req_i.dat[10:0], i_req_i.dat[11]};
    assign new_frame.throttle = i_req_i.dat[10:0];
    assign new_frame.telem    = i_req_i.dat[11];
    // Checksum folds the three nibbles together
    assign new_frame.crc      = cmd[3:0] ^ cmd[7:4] ^ cmd[11:8];

    always_ff @(posedge i_sys_clk) begin
        if (sys_rst) begin
            ack_q   <= 1'b0;
            start_q <= '0;
        end else begin
            ack_q   <= access;
            start_q <= '0;
            // Drop the write if that motor is still sending
            if (access && i_req_i.we && (|i_req_i.sel[1:0]) && thr_hit &&
                !busy[mot_idx] && !start_q[mot_idx]) begin
                start_q[mot_idx] <= 1'b1;
            end
        end
    end

    // Last accepted frame per motor, kept for readback
    always_ff @(posedge i_sys_clk) begin
        if (access && i_req_i.we && (|i_req_i.sel[1:0]) && thr_hit &&
            !busy[mot_idx] && !start_q[mot_idx]) begin
            frame_q[mot_idx] <= new_frame;
        end
    end

    // Read mux, status first then throttle slots
    always_comb begin
        o_rsp_o     = '0;
        o_rsp_o.ack = ack_q;
        if (ofs == DSHOT_STATUS_OFS) begin
            o_rsp_o.dat = wb_data_t'(busy);
        end else if (thr_hit) begin
            o_rsp_o.dat = wb_data_t'(frame_q[mot_idx]);
        end
    end

    // ==============================
    // One serializer per motor
    // ==============================
    for (genvar m = 0; m < N_MOTORS; m++) begin : g_tx
        dshot_tx #(
            .BIT_CYCLES(DSHOT_BIT_CYCLES)
        ) u_tx (
            .i_sys_clk(i_sys_clk),
            .sys_rst  (sys_rst),
            .i_start_i(start_q[m]),
            .i_frame_i(frame_q[m]),
            .o_line_o (o_dshot_o[m]),
            .o_busy_o (busy[m])
        );
    end

    // Start must land on an idle serializer
    a_start_idle: assert property (@(posedge i_sys_clk) disable iff (sys_rst)
        (start_q & busy) == '0);

endmodule

/* hw/wb_motor_mux.sv */
// ==============================
// Pad mode register
// DSHOT drive or serial passthrough on one selected pad
// ==============================
`timescale 1ns/1ps

module wb_motor_mux (
    input  logic                  i_sys_clk,
    input  logic                  sys_rst,
    input  fc_io_pkg::wb_req_t    i_req_i,
    input  fc_io_pkg::motor_vec_t i_dshot_i,
    input  logic                  i_serial_tx_i,
    input  logic                  i_serial_oe_i,
    input  fc_io_pkg::motor_vec_t i_motor_in_i,
    output fc_io_pkg::wb_rsp_t    o_rsp_o,
    output fc_io_pkg::motor_vec_t o_motor_o,
    output fc_io_pkg::motor_vec_t o_motor_oe_o,
    output logic                  o_serial_rx_o
);
    import fc_io_pkg::*;

    // Bit 0 mode (1 = DSHOT), bits 2..1 channel
    logic [2:0] mode_q;
    logic       ack_q;
    logic       access;
    logic       reg_hit;
    logic       dshot_mode;
    logic [1:0] chan;

    assign access     = i_req_i.cyc & i_req_i.stb & ~ack_q;
    assign reg_hit    = i_req_i.adr[7:0] == MODE_OFS;
    assign dshot_mode = mode_q[0];
    assign chan       = mode_q[2:1];

    always_ff @(posedge i_sys_clk) begin
        if (sys_rst) begin
            // Come up driving DSHOT, channel 0
            mode_q <= 3'b001;
            ack_q  <= 1'b0;
        end else begin
            ack_q <= access;
            if (access && i_req_i.we && i_req_i.sel[0] && reg_hit) begin
                mode_q <= i_req_i.dat[2:0];
            end
        end
    end

    always_comb begin
        o_rsp_o     = '0;
        o_rsp_o.ack = ack_q;
        if (reg_hit) begin
            o_rsp_o.dat = wb_data_t'(mode_q);
        end
    end

    // ==============================
    // Pad routing
    // ==============================
    always_comb begin
        if (dshot_mode) begin
            // All pads driven by the serializers
            o_motor_o     = i_dshot_i;
            o_motor_oe_o  = '1;
            o_serial_rx_o = 1'b1;
        end else begin
            // Only the selected pad talks to the ESC, rest held low
            o_motor_o          = '0;
            o_motor_oe_o       = '0;
            o_motor_o[chan]    = i_serial_tx_i;
            o_motor_oe_o[chan] = i_serial_oe_i;
            o_serial_rx_o      = i_motor_in_i[chan];
        end
    end

endmodule

/* hw/fc_io_top.sv */
// ==============================
// Flight-controller peripheral top
// Wishbone decoder with LED, DSHOT and pad mode slaves
// ==============================
`timescale 1ns/1ps

module fc_io_top #(
    parameter int DSHOT_BIT_CYCLES = 120,
    parameter bit LED_ACTIVE_LOW   = 1'b1
) (
    input  logic                          i_sys_clk,
    input  logic                          sys_rst,
    // Host Wishbone port
    input  fc_io_pkg::wb_req_t            i_wb_req_i,
    output fc_io_pkg::wb_rsp_t            o_wb_rsp_o,
    // Status LEDs
    output logic [fc_io_pkg::N_LEDS-1:0]  o_led_o,
    // Serial line towards the ESC
    input  logic                          i_serial_tx_i,
    input  logic                          i_serial_oe_i,
    output logic                          o_serial_rx_o,
    // Motor pads, split value / enable / input
    input  fc_io_pkg::motor_vec_t         i_motor_in_i,
    output fc_io_pkg::motor_vec_t         o_motor_o,
    output fc_io_pkg::motor_vec_t         o_motor_oe_o
);
    import fc_io_pkg::*;

    // Per-slave request and response
    wb_req_t    led_req;
    wb_req_t    dshot_req;
    wb_req_t    mode_req;
    wb_rsp_t    led_rsp;
    wb_rsp_t    dshot_rsp;
    wb_rsp_t    mode_rsp;
    // Raw DSHOT waveforms before pad routing
    motor_vec_t dshot_lines;

    wb_addr_decoder u_decoder (
        .i_sys_clk    (i_sys_clk),
        .sys_rst      (sys_rst),
        .i_req_i      (i_wb_req_i),
        .i_led_rsp_i  (led_rsp),
        .i_dshot_rsp_i(dshot_rsp),
        .i_mode_rsp_i (mode_rsp),
        .o_rsp_o      (o_wb_rsp_o),
        .o_led_req_o  (led_req),
        .o_dshot_req_o(dshot_req),
        .o_mode_req_o (mode_req)
    );

    wb_led_ctrl #(
        .LED_ACTIVE_LOW(LED_ACTIVE_LOW)
    ) u_led (
        .i_sys_clk(i_sys_clk),
        .sys_rst  (sys_rst),
        .i_req_i  (led_req),
        .o_rsp_o  (led_rsp),
        .o_led_o  (o_led_o)
    );

    wb_dshot_ctrl #(
        .DSHOT_BIT_CYCLES(DSHOT_BIT_CYCLES)
    ) u_dshot (
        .i_sys_clk(i_sys_clk),
        .sys_rst  (sys_rst),
        .i_req_i  (dshot_req),
        .o_rsp_o  (dshot_rsp),
        .o_dshot_o(dshot_lines)
    );

    wb_motor_mux u_mode (
        .i_sys_clk    (i_sys_clk),
        .sys_rst      (sys_rst),
        .i_req_i      (mode_req),
        .i_dshot_i    (dshot_lines),
        .i_serial_tx_i(i_serial_tx_i),
        .i_serial_oe_i(i_serial_oe_i),
        .i_motor_in_i (i_motor_in_i),
        .o_rsp_o      (mode_rsp),
        .o_motor_o    (o_motor_o),
        .o_motor_oe_o (o_motor_oe_o),
        .o_serial_rx_o(o_serial_rx_o)
    );

endmodule

/* verification/fc_io_tb.sv */
// ==============================
// Flight-controller IO testbench
// Bus master, DSHOT frame decoder and self-checks
// ==============================
`timescale 1ns/1ps

module fc_io_tb;
    import fc_io_pkg::*;

    localparam int BIT_CYCLES     = 16;
    localparam bit LED_ACTIVE_LOW = 1'b1;
    localparam int N_FRAMES       = N_MOTORS;
    // Frame time at 10 ns per cycle plus margin for bus traffic
    localparam int WATCHDOG_NS    = N_FRAMES * DSHOT_FRAME_BITS * BIT_CYCLES * 10 + 20000;

    // Expected pad outputs for one mode setting
    typedef struct packed {
        motor_vec_t val;
        motor_vec_t oe;
        logic       rx;
    } pad_state_t;

    logic              i_sys_clk;
    logic              sys_rst;
    wb_req_t           wb_req;
    wb_rsp_t           wb_rsp;
    logic [N_LEDS-1:0] led;
    logic              serial_tx;
    logic              serial_oe;
    logic              serial_rx;
    motor_vec_t        motor_in;
    motor_vec_t        motor;
    motor_vec_t        motor_oe;
    int                seed;

    fc_io_top #(
        .DSHOT_BIT_CYCLES(BIT_CYCLES),
        .LED_ACTIVE_LOW  (LED_ACTIVE_LOW)
    ) fc_io_top_i (
        .i_sys_clk    (i_sys_clk),
        .sys_rst      (sys_rst),
        .i_wb_req_i   (wb_req),
        .o_wb_rsp_o   (wb_rsp),
        .o_led_o      (led),
        .i_serial_tx_i(serial_tx),
        .i_serial_oe_i(serial_oe),
        .o_serial_rx_o(serial_rx),
        .i_motor_in_i (motor_in),
        .o_motor_o    (motor),
        .o_motor_oe_o (motor_oe)
    );

    always #5 i_sys_clk = ~i_sys_clk;

    // ==============================
    // Reference model
    // ==============================
    // Checksum is the XOR of the three nibbles of {throttle, telem}
    function automatic dshot_frame_t ref_frame(input logic [10:0] thr, input logic telem);
        dshot_frame_t f;
        f.throttle = thr;
        f.telem    = telem;
        f.crc      = thr[10:7] ^ thr[6:3] ^ {thr[2:0], telem};
        return f;
    endfunction

    // Active-low pins flip every LED bit
    function automatic logic [N_LEDS-1:0] ref_led_pins(input logic [N_LEDS-1:0] v);
        return v ^ {N_LEDS{LED_ACTIVE_LOW}};
    endfunction

    function automatic pad_state_t ref_pads(input logic dshot_mode, input logic [1:0] chan,
                                            input motor_vec_t lines, input logic tx,
                                            input logic oe, input motor_vec_t pad_in);
        pad_state_t p;
        p.rx = dshot_mode ? 1'b1 : pad_in[chan];
        for (int i = 0; i < N_MOTORS; i++) begin
            if (dshot_mode) begin
                p.val[i] = lines[i];
                p.oe[i]  = 1'b1;
            end else if (i == chan) begin
                p.val[i] = tx;
                p.oe[i]  = oe;
            end else begin
                // Unselected pads stay low and undriven in passthrough
                p.val[i] = 1'b0;
                p.oe[i]  = 1'b0;
            end
        end
        return p;
    endfunction

    function automatic wb_addr_t thr_addr(input int n);
        return WIN_DSHOT + wb_addr_t'(DSHOT_THR_OFS) + wb_addr_t'(4 * n);
    endfunction

    // ==============================
    // Compare tasks
    // ==============================
    task automatic abort_run();
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input wb_data_t got, input wb_data_t exp);
        if (got !== exp) begin
            $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_frame(input string name, input dshot_frame_t got,
                               input dshot_frame_t exp);
        if (got !== exp) begin
            $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_pads(input string name, input motor_vec_t got, input motor_vec_t exp);
        if (got !== exp) begin
            $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    // Combinational pads are sampled mid-cycle
    task automatic compare_pads(input pad_state_t exp);
        @(negedge i_sys_clk);
        check_pads("o_motor_o", motor, exp.val);
        check_pads("o_motor_oe_o", motor_oe, exp.oe);
        check_bit("o_serial_rx_o", serial_rx, exp.rx);
    endtask

    // ==============================
    // Bus master
    // ==============================
    task automatic bus_cycle(input wb_addr_t adr, input logic we, input wb_data_t wdat,
                             output wb_rsp_t rsp);
        int waited;
        waited = 0;
        @(posedge i_sys_clk);
        #1;
        wb_req.adr = adr;
        wb_req.dat = wdat;
        wb_req.we  = we;
        wb_req.sel = 4'hf;
        wb_req.stb = 1'b1;
        wb_req.cyc = 1'b1;
        @(posedge i_sys_clk);
        #1;
        // Ack or err is registered and expected one edge after stb
        while (!wb_rsp.ack && !wb_rsp.err) begin
            waited++;
            if (waited >= 4) begin
                $display("Bus access to 0x%h got neither ack nor err", adr);
                abort_run();
            end
            @(posedge i_sys_clk);
            #1;
        end
        rsp    = wb_rsp;
        wb_req = '0;
    endtask

    task automatic write_reg(input wb_addr_t adr, input wb_data_t wdat);
        wb_rsp_t rsp;
        bus_cycle(adr, 1'b1, wdat, rsp);
        check_bit("wb_ack", rsp.ack, 1'b1);
        check_bit("wb_err", rsp.err, 1'b0);
    endtask

    task automatic read_reg(input wb_addr_t adr, output wb_data_t rdat);
        wb_rsp_t rsp;
        bus_cycle(adr, 1'b0, '0, rsp);
        check_bit("wb_ack", rsp.ack, 1'b1);
        check_bit("wb_err", rsp.err, 1'b0);
        rdat = rsp.dat;
    endtask

    // Frame monitor that measures the high time of each bit on one pad
    task automatic decode_frame(input int m, output dshot_frame_t frame);
        logic [DSHOT_FRAME_BITS-1:0] bits;
        int                          wait_cyc;
        int                          hi_cnt;
        wait_cyc = 0;
        @(negedge i_sys_clk);
        while (!motor[m]) begin
            wait_cyc++;
            if (wait_cyc > 16) begin
                $display("No DSHOT frame started on motor %0d", m);
                abort_run();
            end
            @(negedge i_sys_clk);
        end
        for (int b = DSHOT_FRAME_BITS - 1; b >= 0; b--) begin
            hi_cnt = 0;
            for (int c = 0; c < BIT_CYCLES; c++) begin
                if (motor[m]) begin
                    hi_cnt++;
                end
                @(negedge i_sys_clk);
            end
            // More than half the bit high means a 1
            bits[b] = hi_cnt > BIT_CYCLES / 2;
        end
        frame = bits;
    endtask

    // ==============================
    // Test sequence
    // ==============================
    initial begin
        wb_data_t     rdat;
        wb_data_t     val;
        wb_data_t     mode_val;
        wb_rsp_t      rsp;
        dshot_frame_t exp_frame;
        dshot_frame_t got_frame;
        i_sys_clk = 1'b0;
        sys_rst   = 1'b1;
        wb_req    = '0;
        serial_tx = 1'b0;
        serial_oe = 1'b0;
        motor_in  = '0;
        seed      = 32'h42a92298;
        repeat (3) @(posedge i_sys_clk);
        #1;
        sys_rst = 1'b0;

        // Reset state
        read_reg(WIN_LED, rdat);
        check_word("led_reg", rdat, '0);
        check_word("o_led_o", wb_data_t'(led), wb_data_t'(ref_led_pins('0)));
        read_reg(WIN_MODE + wb_addr_t'(MODE_OFS), rdat);
        check_word("mode_reg", rdat, 32'h1);
        read_reg(WIN_DSHOT + wb_addr_t'(DSHOT_STATUS_OFS), rdat);
        check_word("dshot_status", rdat, '0);
        compare_pads(ref_pads(1'b1, 2'd0, '0, serial_tx, serial_oe, motor_in));

        // LED register readback and pin polarity
        for (int i = 0; i < 8; i++) begin
            val = $random(seed);
            write_reg(WIN_LED, val);
            read_reg(WIN_LED, rdat);
            check_word("led_reg", rdat, wb_data_t'(val[N_LEDS-1:0]));
            check_word("o_led_o", wb_data_t'(led), wb_data_t'(ref_led_pins(val[N_LEDS-1:0])));
        end

        // One frame per motor with a second write while busy
        for (int m = 0; m < N_MOTORS; m++) begin
            val       = $random(seed);
            exp_frame = ref_frame(val[10:0], val[11]);
            fork
                decode_frame(m, got_frame);
                begin
                    write_reg(thr_addr(m), val);
                    read_reg(WIN_DSHOT + wb_addr_t'(DSHOT_STATUS_OFS), rdat);
                    check_word("dshot_status", rdat, wb_data_t'(1 << m));
                    write_reg(thr_addr(m), ~val);
                    read_reg(thr_addr(m), rdat);
                    check_frame("dshot_frame_reg", dshot_frame_t'(rdat[15:0]), exp_frame);
                end
            join
            check_frame("motor_frame", got_frame, exp_frame);
            read_reg(WIN_DSHOT + wb_addr_t'(DSHOT_STATUS_OFS), rdat);
            check_word("dshot_status", rdat, '0);
        end

        // Serial passthrough on each channel
        for (int ch = 0; ch < N_MOTORS; ch++) begin
            mode_val = wb_data_t'({ch[1:0], 1'b0});
            write_reg(WIN_MODE + wb_addr_t'(MODE_OFS), mode_val);
            read_reg(WIN_MODE + wb_addr_t'(MODE_OFS), rdat);
            check_word("mode_reg", rdat, mode_val);
            for (int k = 0; k < 4; k++) begin
                @(posedge i_sys_clk);
                #1;
                serial_tx = k[0];
                serial_oe = k[1];
                val       = $random(seed);
                motor_in  = val[N_MOTORS-1:0];
                compare_pads(ref_pads(1'b0, ch[1:0], '0, serial_tx, serial_oe, motor_in));
            end
        end
        write_reg(WIN_MODE + wb_addr_t'(MODE_OFS), 32'h1);
        compare_pads(ref_pads(1'b1, 2'd0, '0, serial_tx, serial_oe, motor_in));

        // Unmapped window followed by a normal access
        bus_cycle(32'h0000_0200, 1'b0, '0, rsp);
        check_bit("wb_err", rsp.err, 1'b1);
        check_bit("wb_ack", rsp.ack, 1'b0);
        check_word("wb_dat", rsp.dat, '0);
        read_reg(WIN_MODE + wb_addr_t'(MODE_OFS), rdat);
        check_word("mode_reg", rdat, 32'h1);

        $display("SIMULATION PASSED");
        $finish;
    end

    // Watchdog sized from the frame count
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
        abort_run();
    end

endmodule

/* fc_io.f */
hw/fc_io_pkg.sv
hw/dshot_tx.sv
hw/wb_addr_decoder.sv
hw/wb_led_ctrl.sv
hw/wb_dshot_ctrl.sv
hw/wb_motor_mux.sv
hw/fc_io_top.sv
verification/fc_io_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := fc_io_tb
FILELIST  := fc_io.f
VFLAGS    := --binary --timing --assert -Wno-fatal
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuild only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
